//--- design/mpad_macros.svh
/*
 * Widths and depths shared by the mirror-padding DMA design.
 * MPAD_FIFO_DEPTH also caps the number of AXI reads in flight
 * and must stay a power of two of at least 2.
 */
`ifndef MPAD_MACROS_SVH
`define MPAD_MACROS_SVH

// AXI byte address
`define MPAD_ADDR_W 32

// One matrix element per beat
`define MPAD_DATA_W 32

// Source width N, legal range 2..63
`define MPAD_DIM_W 6

// FIFO entries, equals max outstanding reads
`define MPAD_FIFO_DEPTH 4

`endif

//--- design/mpad_pkg.sv
/*
 * Types shared by the mirror-padding DMA blocks.
 * Output indices are one bit wider than N to reach N+1.
 */
`include "mpad_macros.svh"

package mpad_pkg;

    // Byte address on the AXI bus
    typedef logic [`MPAD_ADDR_W-1:0] addr_t;

    // Matrix element
    typedef logic [`MPAD_DATA_W-1:0] data_t;

    // Source matrix width N
    typedef logic [`MPAD_DIM_W-1:0] dim_t;

    // Output row or column, 0..N+1
    typedef logic [`MPAD_DIM_W:0] idx_t;

    // Destination write command, one per output element
    typedef struct packed {
        addr_t addr;
        logic  last;    // Final element of the padded matrix
    } wr_cmd_t;

endpackage

//--- design/mpad_fifo.sv
/*
 * Synchronous FIFO, first-word-fall-through output.
 * DEPTH must be a power of two of at least 2.
 * The producer must never push when full; the consumer never pops when empty.
 */
`timescale 1ns/1ps
`include "mpad_macros.svh"

module mpad_fifo #(
    parameter type payload_t = mpad_pkg::data_t,
    parameter int  DEPTH     = `MPAD_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     push_i,
    input  payload_t push_data_i,
    output logic     full_o,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     empty_o
);
    import mpad_pkg::*;

    localparam int PTR_W = $clog2(DEPTH);

    payload_t           mem [DEPTH];   // No reset on storage
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;

    assign full_o     = (count == (PTR_W+1)'(DEPTH));
    assign empty_o    = (count == '0);
    assign pop_data_o = mem[rd_ptr];   // Head entry, valid while not empty

    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    // Pointers wrap naturally at a power-of-two depth
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_i, pop_i})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // Both or neither
            endcase
        end
    end

    // Upstream flow control is expected to prevent these
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        push_i |-> !full_o)
        else $error("mpad_fifo: push while full");

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        pop_i |-> !empty_o)
        else $error("mpad_fifo: pop while empty");

endmodule

//--- design/mpad_addr_gen.sv
/*
 * Walks the (N+2)x(N+2) output matrix in row-major order and issues
 * one single-beat read per element, at most MPAD_FIFO_DEPTH in flight.
 * N must be 2..63; configuration is sampled only when a start is accepted.
 */
`timescale 1ns/1ps
`include "mpad_macros.svh"

module mpad_addr_gen (
    input  logic              clk,
    input  logic              rst_n,
    input  mpad_pkg::addr_t   src_addr_i,
    input  mpad_pkg::addr_t   dst_addr_i,
    input  mpad_pkg::dim_t    mat_width_i,
    input  logic              start_i,
    output logic              done_o,
    output mpad_pkg::addr_t   araddr_o,
    output logic              arvalid_o,
    input  logic              arready_i,
    output logic              cmd_push_o,
    output mpad_pkg::wr_cmd_t cmd_o,
    input  logic              data_pop_i,
    input  logic              last_write_done_i
);
    import mpad_pkg::*;

    localparam int CNT_W = $clog2(`MPAD_FIFO_DEPTH) + 1;

    // Reflection without repeating the edge: 0 -> 1, N+1 -> N-2, else i-1
    function automatic idx_t mirror_idx(input idx_t out_idx, input idx_t n);
        idx_t src_idx;
        if (out_idx == '0) begin
            src_idx = idx_t'(1);
        end else if (out_idx == n + 1'b1) begin
            src_idx = n - idx_t'(2);
        end else begin
            src_idx = out_idx - 1'b1;
        end
        return src_idx;
    endfunction

    addr_t            src_base;   // Latched at start
    addr_t            dst_base;
    dim_t             width;
    idx_t             n_ext;
    idx_t             row;
    idx_t             col;
    idx_t             src_row;
    idx_t             src_col;
    logic             issuing;    // Elements left to request
    logic             at_last;
    logic             ar_fire;
    logic             start_ok;
    logic [CNT_W-1:0] inflight;   // Reads issued, data not yet popped
    addr_t            src_off;
    addr_t            dst_off;

    assign n_ext   = {1'b0, width};
    assign src_row = mirror_idx(row, n_ext);
    assign src_col = mirror_idx(col, n_ext);
    assign at_last = (row == n_ext + 1'b1) && (col == n_ext + 1'b1);

    // Word offsets scaled to bytes
    assign src_off = (addr_t'(src_row) * addr_t'(width) + addr_t'(src_col)) << 2;
    assign dst_off = (addr_t'(row) * addr_t'(n_ext + idx_t'(2)) + addr_t'(col)) << 2;

    // Held until accepted, since row/col only move on a transfer
    assign arvalid_o  = issuing && (inflight < CNT_W'(`MPAD_FIFO_DEPTH));
    assign araddr_o   = src_base + src_off;
    assign ar_fire    = arvalid_o && arready_i;
    assign cmd_push_o = ar_fire;
    assign cmd_o.addr = dst_base + dst_off;
    assign cmd_o.last = at_last;

    assign start_ok = start_i && done_o;   // Ignored while busy

    always_ff @(posedge clk) begin
        if (start_ok) begin
            src_base <= src_addr_i;
            dst_base <= dst_addr_i;
            width    <= mat_width_i;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            done_o  <= 1'b1;
            issuing <= 1'b0;
            row     <= '0;
            col     <= '0;
        end else if (start_ok) begin
            done_o  <= 1'b0;
            issuing <= 1'b1;
            row     <= '0;
            col     <= '0;
        end else begin
            if (ar_fire) begin
                if (at_last) begin
                    issuing <= 1'b0;
                end else if (col == n_ext + 1'b1) begin
                    col <= '0;
                    row <= row + 1'b1;
                end else begin
                    col <= col + 1'b1;
                end
            end
            if (last_write_done_i) begin
                done_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inflight <= '0;
        end else begin
            case ({ar_fire, data_pop_i})
                2'b10:   inflight <= inflight + 1'b1;
                2'b01:   inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    a_width_legal: assert property (@(posedge clk) disable iff (!rst_n)
        start_ok |-> (mat_width_i >= dim_t'(2)))
        else $error("mpad_addr_gen: start with width below 2");

endmodule

//--- design/mpad_writer.sv
/*
 * Pops one destination command and one read word together and issues
 * a single-beat AXI write. Only one write is outstanding at a time.
 * AW and W may complete in either order.
 */
`timescale 1ns/1ps

module mpad_writer (
    input  logic              clk,
    input  logic              rst_n,
    input  mpad_pkg::wr_cmd_t cmd_i,
    input  logic              cmd_empty_i,
    input  mpad_pkg::data_t   data_i,
    input  logic              data_empty_i,
    output logic              pop_o,
    output mpad_pkg::addr_t   awaddr_o,
    output logic              awvalid_o,
    input  logic              awready_i,
    output mpad_pkg::data_t   wdata_o,
    output logic              wvalid_o,
    input  logic              wready_i,
    output logic              wlast_o,
    input  logic              bvalid_i,
    output logic              bready_o,
    output logic              last_write_done_o
);
    import mpad_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR_DATA,
        S_RESP
    } state_t;

    state_t state;
    logic   aw_sent;
    logic   w_sent;
    logic   last_q;    // Current write closes the matrix
    logic   aw_fire;
    logic   w_fire;
    logic   b_fire;
    logic   aw_done;
    logic   w_done;

    assign pop_o     = (state == S_IDLE) && !cmd_empty_i && !data_empty_i;
    assign awvalid_o = (state == S_ADDR_DATA) && !aw_sent;
    assign wvalid_o  = (state == S_ADDR_DATA) && !w_sent;
    assign wlast_o   = wvalid_o;   // Single-beat bursts
    assign bready_o  = (state == S_RESP);

    assign aw_fire = awvalid_o && awready_i;
    assign w_fire  = wvalid_o && wready_i;
    assign b_fire  = bvalid_i && bready_o;
    assign aw_done = aw_sent || aw_fire;
    assign w_done  = w_sent || w_fire;

    assign last_write_done_o = b_fire && last_q;

    // Payload held steady through both handshakes
    always_ff @(posedge clk) begin
        if (pop_o) begin
            awaddr_o <= cmd_i.addr;
            wdata_o  <= data_i;
            last_q   <= cmd_i.last;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (pop_o) begin
                        aw_sent <= 1'b0;
                        w_sent  <= 1'b0;
                        state   <= S_ADDR_DATA;
                    end
                end
                S_ADDR_DATA: begin
                    aw_sent <= aw_done;
                    w_sent  <= w_done;
                    if (aw_done && w_done) begin
                        state <= S_RESP;
                    end
                end
                S_RESP: begin
                    if (b_fire) begin
                        state <= S_IDLE;   // Next pair pops next cycle
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Slave answers only after both AW and W have been accepted
    a_b_expected: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid_i |-> (state == S_RESP))
        else $error("mpad_writer: B response with no write outstanding");

endmodule

//--- design/mpad_engine.sv
/*
 * Mirror-padding DMA top level with single-beat AXI reads and writes.
 * AXI ID, LEN, SIZE, BURST and STRB are constant and tied off outside.
 * Response codes on R and B are not checked.
 */
`timescale 1ns/1ps

module mpad_engine (
    input  logic            clk,
    input  logic            rst_n,
    input  mpad_pkg::addr_t src_addr_i,
    input  mpad_pkg::addr_t dst_addr_i,
    input  mpad_pkg::dim_t  mat_width_i,
    input  logic            start_i,
    output logic            done_o,
    output mpad_pkg::addr_t araddr_o,
    output logic            arvalid_o,
    input  logic            arready_i,
    input  mpad_pkg::data_t rdata_i,
    input  logic            rvalid_i,
    output logic            rready_o,
    output mpad_pkg::addr_t awaddr_o,
    output logic            awvalid_o,
    input  logic            awready_i,
    output mpad_pkg::data_t wdata_o,
    output logic            wlast_o,
    output logic            wvalid_o,
    input  logic            wready_i,
    input  logic            bvalid_i,
    output logic            bready_o
);
    import mpad_pkg::*;

    wr_cmd_t cmd_in;
    wr_cmd_t cmd_out;
    logic    cmd_push;
    logic    cmd_empty;
    data_t   data_out;
    logic    data_full;
    logic    data_empty;
    logic    pair_pop;     // Pops both FIFOs together
    logic    last_write_done;

    assign rready_o = !data_full;

    mpad_addr_gen i_addr_gen (
        .clk               (clk),
        .rst_n             (rst_n),
        .src_addr_i        (src_addr_i),
        .dst_addr_i        (dst_addr_i),
        .mat_width_i       (mat_width_i),
        .start_i           (start_i),
        .done_o            (done_o),
        .araddr_o          (araddr_o),
        .arvalid_o         (arvalid_o),
        .arready_i         (arready_i),
        .cmd_push_o        (cmd_push),
        .cmd_o             (cmd_in),
        .data_pop_i        (pair_pop),
        .last_write_done_i (last_write_done)
    );

    // Never full on push thanks to the in-flight limit
    mpad_fifo #(.payload_t(wr_cmd_t)) cmd_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (cmd_push),
        .push_data_i (cmd_in),
        .full_o      (),
        .pop_i       (pair_pop),
        .pop_data_o  (cmd_out),
        .empty_o     (cmd_empty)
    );

    mpad_fifo #(.payload_t(data_t)) data_fifo (
        .clk         (clk),
        .rst_n       (rst_n),
        .push_i      (rvalid_i && rready_o),   // R transfer
        .push_data_i (rdata_i),
        .full_o      (data_full),
        .pop_i       (pair_pop),
        .pop_data_o  (data_out),
        .empty_o     (data_empty)
    );

    mpad_writer i_writer (
        .clk               (clk),
        .rst_n             (rst_n),
        .cmd_i             (cmd_out),
        .cmd_empty_i       (cmd_empty),
        .data_i            (data_out),
        .data_empty_i      (data_empty),
        .pop_o             (pair_pop),
        .awaddr_o          (awaddr_o),
        .awvalid_o         (awvalid_o),
        .awready_i         (awready_i),
        .wdata_o           (wdata_o),
        .wvalid_o          (wvalid_o),
        .wready_i          (wready_i),
        .wlast_o           (wlast_o),
        .bvalid_i          (bvalid_i),
        .bready_o          (bready_o),
        .last_write_done_o (last_write_done)
    );

endmodule

//--- bench/mpad_clk_gen.sv
/*
 * Free-running testbench clock with an active-low reset.
 * Reset is released on a rising edge after RESET_CYCLES edges.
 */
`timescale 1ns/1ps

module mpad_clk_gen #(
    parameter real PERIOD_NS    = 20.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;   // Released on an edge like every other input
    end

endmodule

//--- bench/tb_mpad_engine.sv
/*
 * Testbench for the mirror-padding DMA engine with a sparse AXI memory.
 * Tests are read from bench/mpad_tests.txt relative to the project root.
 * Stall mode 1 randomises every ready and valid that the memory drives.
 */
`timescale 1ns/1ps

module tb_mpad_engine;
    import mpad_pkg::*;

    localparam int    MAX_TESTS = 64;
    localparam string TEST_FILE = "bench/mpad_tests.txt";

    logic  clk;
    logic  rst_n;
    addr_t src_addr  = '0;
    addr_t dst_addr  = '0;
    dim_t  mat_width = dim_t'(2);
    logic  start     = 1'b0;
    logic  done;
    addr_t araddr;
    logic  arvalid;
    logic  arready   = 1'b0;
    data_t rdata     = '0;
    logic  rvalid    = 1'b0;
    logic  rready;
    addr_t awaddr;
    logic  awvalid;
    logic  awready   = 1'b0;
    data_t wdata;
    logic  wlast;
    logic  wvalid;
    logic  wready    = 1'b0;
    logic  bvalid    = 1'b0;
    logic  bready;

    // Test table as read from the file
    int    test_n     [MAX_TESTS];
    addr_t test_src   [MAX_TESTS];
    addr_t test_dst   [MAX_TESTS];
    data_t test_seed  [MAX_TESTS];
    int    test_stall [MAX_TESTS];
    int    num_tests  = 0;

    int    cur_n      = 2;
    addr_t cur_src    = '0;
    addr_t cur_dst    = '0;
    data_t cur_seed   = '0;
    int    stall_mode = 0;

    int          error_count  = 0;
    int          read_count   = 0;
    int          write_count  = 0;
    int          b_count      = 0;
    int          limit_cycles = 0;
    logic        tests_loaded = 1'b0;
    logic [15:0] lfsr         = 16'd12;
    logic        b_pend       = 1'b0;   // Write stored but response not yet raised

    data_t mem [addr_t];   // Byte address to word
    addr_t rd_q [$];
    addr_t aw_q [$];
    data_t w_q  [$];

    mpad_clk_gen i_clk_gen (
        .clk_o   (clk),
        .rst_n_o (rst_n)
    );

    mpad_engine i_mpad_engine (
        .clk         (clk),
        .rst_n       (rst_n),
        .src_addr_i  (src_addr),
        .dst_addr_i  (dst_addr),
        .mat_width_i (mat_width),
        .start_i     (start),
        .done_o      (done),
        .araddr_o    (araddr),
        .arvalid_o   (arvalid),
        .arready_i   (arready),
        .rdata_i     (rdata),
        .rvalid_i    (rvalid),
        .rready_o    (rready),
        .awaddr_o    (awaddr),
        .awvalid_o   (awvalid),
        .awready_i   (awready),
        .wdata_o     (wdata),
        .wlast_o     (wlast),
        .wvalid_o    (wvalid),
        .wready_i    (wready),
        .bvalid_i    (bvalid),
        .bready_o    (bready)
    );

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic draw_handshake(output logic ready);
        if (stall_mode == 0) begin
            ready = 1'b1;
        end else begin
            lfsr  = lfsr_next(lfsr);
            ready = lfsr[0];   // One step per bit taken
        end
    endtask

    // Mirror without repeating the edge element
    function automatic int reflect_index(input int k, input int n);
        int m;
        if (k < 0) begin
            m = 1;
        end else if (k == n) begin
            m = n - 2;
        end else begin
            m = k;
        end
        return m;
    endfunction

    function automatic data_t expected_word(input int r, input int c);
        int src_r;
        int src_c;
        src_r = reflect_index(r - 1, cur_n);
        src_c = reflect_index(c - 1, cur_n);
        return cur_seed + data_t'(src_r * 256 + src_c);
    endfunction

    function automatic data_t mem_word(input addr_t a);
        data_t d;
        d = mem.exists(a) ? mem[a] : (a ^ 32'ha5a5_a5a5);   // Unfilled words follow the address
        return d;
    endfunction

    function automatic logic in_region(input addr_t a, input addr_t base, input int words);
        return (a >= base) && (a < base + addr_t'(4 * words)) && (a[1:0] == 2'b00);
    endfunction

    task automatic verify_flag(input string name, input logic got, input logic exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic commit_write(input addr_t a, input data_t d);
        int words;
        words = (cur_n + 2) * (cur_n + 2);
        assert (in_region(a, cur_dst, words)) else begin
            $display("CHECK FAILED awaddr_o: got 0x%08h, expected 0x%08h to 0x%08h",
                     a, cur_dst, cur_dst + addr_t'(4 * words - 4));
            error_count++;
        end
        mem[a] = d;
        write_count++;
    endtask

    // AXI memory model for all five channels
    always @(posedge clk) begin : axi_slave
        logic ready_bit;
        logic r_free;
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
            awready <= 1'b0;
            wready  <= 1'b0;
            bvalid  <= 1'b0;
            b_pend  = 1'b0;
            rd_q.delete();
            aw_q.delete();
            w_q.delete();
        end else begin
            if (arvalid && arready) begin
                read_count++;
                assert (in_region(araddr, cur_src, cur_n * cur_n)) else begin
                    $display("CHECK FAILED araddr_o: got 0x%08h, expected 0x%08h to 0x%08h",
                             araddr, cur_src, cur_src + addr_t'(4 * cur_n * cur_n - 4));
                    error_count++;
                end
                rd_q.push_back(araddr);
            end
            draw_handshake(ready_bit);
            arready <= ready_bit;

            r_free = !rvalid || rready;   // Beat held until taken
            if (r_free) begin
                draw_handshake(ready_bit);
                if (rd_q.size() > 0 && ready_bit) begin
                    rdata  <= mem_word(rd_q.pop_front());
                    rvalid <= 1'b1;
                end else begin
                    rvalid <= 1'b0;
                end
            end

            if (awvalid && awready) begin
                aw_q.push_back(awaddr);
            end
            if (wvalid && wready) begin
                w_q.push_back(wdata);
            end
            if (wvalid) begin
                verify_flag("wlast_o", wlast, 1'b1);
            end
            draw_handshake(ready_bit);
            awready <= ready_bit;
            draw_handshake(ready_bit);
            wready <= ready_bit;

            // Store once address and data have both arrived
            if (aw_q.size() > 0 && w_q.size() > 0) begin
                commit_write(aw_q.pop_front(), w_q.pop_front());
                b_pend = 1'b1;
            end

            if (bvalid && bready) begin
                bvalid <= 1'b0;
                b_count++;
            end else if (b_pend && !bvalid) begin
                draw_handshake(ready_bit);
                if (ready_bit) begin
                    bvalid <= 1'b1;
                    b_pend = 1'b0;
                end
            end
        end
    end

    task automatic load_tests();
        int    fd;
        int    got;
        int    n;
        int    st;
        addr_t s;
        addr_t d;
        data_t seed;
        string line;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open %s, no tests can run", TEST_FILE);
            error_count++;
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                got = $fgets(line, fd);
                if (got > 0 && line.len() > 1 && line[0] != "#") begin
                    if ($sscanf(line, "%d %h %h %h %d", n, s, d, seed, st) != 5) begin
                        $display("Malformed line in test file: %s", line);
                        error_count++;
                    end else if (n < 2 || n > 63) begin
                        $display("Test file asks for width %0d, outside 2 to 63", n);
                        error_count++;
                    end else begin
                        test_n[num_tests]     = n;
                        test_src[num_tests]   = s;
                        test_dst[num_tests]   = d;
                        test_seed[num_tests]  = seed;
                        test_stall[num_tests] = st;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
            if (num_tests == 0) begin
                $display("Test file holds no tests to run");
                error_count++;
            end
        end
    endtask

    task automatic fill_source();
        mem.delete();
        for (int i = 0; i < cur_n; i++) begin
            for (int j = 0; j < cur_n; j++) begin
                mem[cur_src + addr_t'(4 * (i * cur_n + j))] = cur_seed + data_t'(i * 256 + j);
            end
        end
    endtask

    task automatic run_test(input int idx, output logic ok);
        int    errs_before;
        int    side;
        int    cycles;
        addr_t a;
        errs_before = error_count;
        cur_n       = test_n[idx];
        cur_src     = test_src[idx];
        cur_dst     = test_dst[idx];
        cur_seed    = test_seed[idx];
        stall_mode  = test_stall[idx];
        side        = cur_n + 2;
        fill_source();
        read_count  = 0;
        write_count = 0;
        b_count     = 0;

        src_addr  <= cur_src;
        dst_addr  <= cur_dst;
        mat_width <= dim_t'(cur_n);
        start     <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(posedge clk);
        verify_flag("done_o", done, 1'b0);

        // Start pulses and a swapped configuration while busy
        for (int k = 0; k < 8; k++) begin
            start     <= (k % 2 == 1);
            mat_width <= dim_t'((cur_n == 2) ? 3 : 2);
            src_addr  <= cur_dst;
            dst_addr  <= cur_src;
            @(posedge clk);
            verify_flag("done_o", done, 1'b0);
        end
        start     <= 1'b0;
        src_addr  <= cur_src;
        dst_addr  <= cur_dst;
        mat_width <= dim_t'(cur_n);

        cycles = 10;
        while (done !== 1'b1) begin
            @(posedge clk);
            cycles++;
        end

        // done_o must not rise before the last response
        compare_word("B transfers on bvalid_i", b_count, side * side);
        compare_word("writes on awvalid_o", write_count, side * side);
        compare_word("reads on arvalid_o", read_count, side * side);
        for (int r = 0; r < side; r++) begin
            for (int c = 0; c < side; c++) begin
                a = cur_dst + addr_t'(4 * (r * side + c));
                assert (mem.exists(a)) else begin
                    $display("Destination row %0d col %0d at 0x%08h was never written", r, c, a);
                    error_count++;
                end
                if (mem.exists(a)) begin
                    compare_word($sformatf("wdata_o at 0x%08h", a), mem[a], expected_word(r, c));
                end
            end
        end

        ok = (error_count == errs_before);
        $display("test %0d: N=%0d stall=%0d writes=%0d cycles=%0d %s", idx, cur_n,
                 stall_mode, write_count, cycles, ok ? "passed" : "failed");
    endtask

    initial begin
        int   passed;
        logic ok;
        passed = 0;
        load_tests();
        limit_cycles = 1000;   // Reset plus margin
        for (int i = 0; i < num_tests; i++) begin
            limit_cycles += 20 * (test_n[i] + 2) * (test_n[i] + 2);
        end
        tests_loaded = 1'b1;

        wait (rst_n === 1'b1);
        @(posedge clk);
        verify_flag("done_o", done, 1'b1);
        verify_flag("arvalid_o", arvalid, 1'b0);
        verify_flag("awvalid_o", awvalid, 1'b0);
        verify_flag("wvalid_o", wvalid, 1'b0);
        verify_flag("bready_o", bready, 1'b0);

        for (int i = 0; i < num_tests; i++) begin
            run_test(i, ok);
            if (ok) begin
                passed++;
            end
        end

        $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
                 num_tests, passed, num_tests - passed, error_count);
        if (error_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    // Watchdog sized from the widths in the test file
    initial begin
        wait (tests_loaded === 1'b1);
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the engine stopped making progress",
                 limit_cycles);
        $display("Test FAILED");
        $finish;
    end

endmodule

//--- bench/mpad_tests.txt
# Columns: N (decimal), source base (hex), destination base (hex), fill seed (hex), stall mode
# Stall mode 0 is a memory that never stalls, 1 randomises every handshake
2  00001000 00080000 00000000 0
3  00002000 00090000 10000000 0
5  00003000 000a0000 20000000 0
8  00004000 000b0000 30000000 0
63 00010000 00100000 40000000 0
2  00005000 000c0000 50000000 1
4  00006000 000d0000 60000000 1
7  00007000 000e0000 70000000 1
16 00008000 000f0000 80000000 1
63 00020000 00200000 90000000 1

//--- files.f
+incdir+design
design/mpad_pkg.sv
design/mpad_fifo.sv
design/mpad_addr_gen.sv
design/mpad_writer.sv
design/mpad_engine.sv
bench/mpad_clk_gen.sv
bench/tb_mpad_engine.sv

//--- Bender.yml
package:
  name: mpad_engine

sources:
  - include_dirs:
      - design
    files:
      - design/mpad_pkg.sv
      - design/mpad_fifo.sv
      - design/mpad_addr_gen.sv
      - design/mpad_writer.sv
      - design/mpad_engine.sv
  - target: test
    files:
      - bench/mpad_clk_gen.sv
      - bench/tb_mpad_engine.sv
